// ==== tb.f ====
logic/lease_pkg.sv
logic/lease_lookup_table.sv
logic/lease_line_tracker.sv
logic/lease_stats.sv
logic/lease_cache_top.sv
verification/lease_clock_gen.sv
verification/lease_cache_props.sv
verification/lease_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lease cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module lease_cache_tb \
	-Mdir obj_dir -o lease_cache_sim

./obj_dir/lease_cache_sim 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== verification/lease_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_cache_tb;

	import lease_pkg::*;

	// clock, reset and DUT
	// --------------------
	logic                     clock;
	logic                     resetn;
	logic                     reset_req;
	logic                     cfg_wren;
	logic [BW_ADDR_SPACE-1:0] cfg_addr;
	cfg_word_u                cfg_data;
	access_req_t              acc_drv;
	access_result_t           result;
	lease_stats_t             stats;

	lease_clock_gen u_clk (.reset_req_i(reset_req), .clock_o(clock), .resetn_o(resetn));

	lease_cache_top uut (
		.clock_i    (clock),
		.resetn_i   (resetn),
		.cfg_wren_i (cfg_wren),
		.cfg_addr_i (cfg_addr),
		.cfg_data_i (cfg_data),
		.access_i   (acc_drv),
		.result_o   (result),
		.stats_o    (stats)
	);

	// reference model state
	// --------------------
	logic [N_ENTRIES-1:0]   tv_m;	// entry written
	logic [BW_REF_ADDR-1:0] tref_m   [N_ENTRIES];
	logic [BW_LEASE-1:0]    tlease_m [N_ENTRIES];
	logic [BW_BLOCK-1:0]    tag_m    [N_LINES];
	logic [BW_LEASE-1:0]    rem_m    [N_LINES];	// remaining lease per line
	lease_stats_t           stats_m;
	access_result_t         exp_q [$];	// expected results, access order
	logic [15:0]            lfsr_q;
	int                     value_errs;
	int                     other_errs;
	int                     n_checked;

	// 16 bit Galois LFSR stepped once per bit
	function automatic logic lfsr_step();
		logic out;
		out    = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (out) begin
			lfsr_q = lfsr_q ^ 16'hB400;
		end
		return out;
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic void model_reset();
		tv_m    = '0;
		stats_m = '0;
		for (int i = 0; i < N_ENTRIES; i++) begin
			tref_m[i]   = '0;
			tlease_m[i] = '0;
		end
		for (int i = 0; i < N_LINES; i++) begin
			tag_m[i] = '0;
			rem_m[i] = '0;
		end
	endfunction

	// decodes the raw word as a byte address or a low bit lease
	function automatic void model_write(input logic [BW_ADDR_SPACE-1:0] addr, input cfg_word_u d);
		logic [BW_ENTRIES-1:0] idx;
		logic [31:0]           raw;
		idx = addr[BW_ENTRIES-1:0];
		raw = d;
		if (addr[BW_ADDR_SPACE-1 -: 2] == 2'd0) begin
			tv_m[idx]   = 1'b1;
			tref_m[idx] = raw[BW_REF_ADDR+1:2];	// byte to word address
		end else if (addr[BW_ADDR_SPACE-1 -: 2] == 2'd1) begin
			tlease_m[idx] = raw[BW_LEASE-1:0];
		end
	endfunction

	// expected outcome of one access with model update
	function automatic access_result_t model_access(input access_req_t req);
		access_result_t      r;
		logic                tab_hit;
		logic [BW_LEASE-1:0] tab_lease;
		int                  hit_line;
		int                  free_line;
		r         = '0;
		r.valid   = 1'b1;
		tab_hit   = 1'b0;
		tab_lease = '0;
		hit_line  = -1;
		free_line = -1;
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (tv_m[i] && tref_m[i] == req.ref_addr) begin
				tab_hit   = 1'b1;
				tab_lease = tlease_m[i];	// later index overrides
			end
		end
		for (int i = 0; i < N_LINES; i++) begin
			if (rem_m[i] != 0 && tag_m[i] == req.block) begin
				hit_line = i;
			end else if (rem_m[i] != 0) begin
				rem_m[i] = rem_m[i] - 8'd1;	// others count down
			end
		end
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (rem_m[i] == 0) begin
				free_line = i;
			end
		end
		r.llt_hit = tab_hit;
		if (hit_line >= 0) begin
			r.cache_hit     = 1'b1;
			r.lease         = tab_hit ? tab_lease : 8'd0;	// table miss expires
			r.line          = BW_LINE'(hit_line);
			rem_m[hit_line] = r.lease;
		end else if (tab_hit && tab_lease != 0 && free_line >= 0) begin
			r.lease          = tab_lease;
			r.line           = BW_LINE'(free_line);
			rem_m[free_line] = tab_lease;
			tag_m[free_line] = req.block;
		end else begin
			r.bypass = 1'b1;
		end
		if (r.cache_hit) stats_m.hits = stats_m.hits + 16'd1;
		else stats_m.misses = stats_m.misses + 16'd1;
		if (r.bypass) stats_m.bypasses = stats_m.bypasses + 16'd1;
		if (!r.llt_hit) stats_m.llt_misses = stats_m.llt_misses + 16'd1;
		return r;
	endfunction

	// checks
	// --------------------
	task automatic report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAIL %0t %s got %0h exp %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_result(input access_result_t got, input access_result_t exp);
		n_checked++;
		report_mismatch("result_o.cache_hit", 32'(got.cache_hit), 32'(exp.cache_hit));
		report_mismatch("result_o.llt_hit", 32'(got.llt_hit), 32'(exp.llt_hit));
		report_mismatch("result_o.bypass", 32'(got.bypass), 32'(exp.bypass));
		report_mismatch("result_o.lease", 32'(got.lease), 32'(exp.lease));
		if (!exp.bypass) begin
			report_mismatch("result_o.line", 32'(got.line), 32'(exp.line));
		end
	endtask

	task automatic check_stats(input lease_stats_t got, input lease_stats_t exp);
		report_mismatch("stats_o.hits", 32'(got.hits), 32'(exp.hits));
		report_mismatch("stats_o.misses", 32'(got.misses), 32'(exp.misses));
		report_mismatch("stats_o.bypasses", 32'(got.bypasses), 32'(exp.bypasses));
		report_mismatch("stats_o.llt_misses", 32'(got.llt_misses), 32'(exp.llt_misses));
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (resetn === 1'b1 && result.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("result_o.valid at %0t with no access outstanding", $time);
			end else begin
				check_result(result, exp_q.pop_front());
			end
		end
	end

	// stimulus
	// --------------------
	// model sees the access before the write, as the DUT does
	task automatic drive(input logic wr, input logic [BW_ADDR_SPACE-1:0] addr,
		input cfg_word_u data, input access_req_t acc);
		@(negedge clock);
		cfg_wren = wr;
		cfg_addr = addr;
		cfg_data = data;
		acc_drv  = acc;
		if (acc.valid) begin
			exp_q.push_back(model_access(acc));
		end
		if (wr) model_write(addr, data);
	endtask

	task automatic send_access(input logic [BW_REF_ADDR-1:0] r, input logic [BW_BLOCK-1:0] b);
		access_req_t a;
		a = {1'b1, r, b};
		drive(1'b0, '0, '0, a);
	endtask

	task automatic write_ref(input int idx, input logic [BW_REF_ADDR-1:0] r);
		cfg_word_u w;
		w = '0;
		w.ref_view.word_addr = r;
		w.ref_view.byte_sel  = 2'd2;	// byte offset is dropped
		drive(1'b1, {SEL_REF_ADDR, BW_ENTRIES'(idx)}, w, '0);
	endtask

	task automatic write_lease(input logic [1:0] sel, input int idx, input logic [BW_LEASE-1:0] l);
		cfg_word_u w;
		w = '0;
		w.lease_view.lease = l;
		drive(1'b1, {sel, BW_ENTRIES'(idx)}, w, '0);
	endtask

	task automatic run_directed();
		logic [BW_LEASE-1:0] leases [N_ENTRIES];
		cfg_word_u           w;
		leases = '{8'd20, 8'd5, 8'd2, 8'd30, 8'd1, 8'd25, 8'd4, 8'd0};
		w = '0;
		w.ref_view.word_addr = 12'h040;
		drive(1'b1, {SEL_REF_ADDR, 3'd0}, w, {1'b1, 12'h040, 16'h0010});	// sees the old table
		for (int i = 1; i < N_ENTRIES; i++) write_ref(i, 12'h040 + 12'(i));
		for (int i = 0; i < N_ENTRIES; i++) write_lease(SEL_LEASE0, i, leases[i]);
		write_lease(2'd2, 1, 8'h7F);	// unkept table is ignored
		send_access(12'h041, 16'h0020);	// lease 5 into line 0
		send_access(12'h04F, 16'h0021);	// unwritten ref gives bypass
		send_access(12'h042, 16'h0020);	// hit refreshes to 2
		send_access(12'h04E, 16'h0022);
		send_access(12'h04E, 16'h0023);	// line 0 runs out
		send_access(12'h041, 16'h0020);	// miss and reallocation
		send_access(12'h043, 16'h0030);
		send_access(12'h045, 16'h0031);
		send_access(12'h040, 16'h0032);	// all four lines live
		send_access(12'h043, 16'h0033);	// no free line so bypass
		send_access(12'h043, 16'h0034);	// line 0 expired and taken
		send_access(12'h04D, 16'h0031);	// hit on table miss expires line 2
		send_access(12'h044, 16'h0035);	// lowest free is line 2
		write_ref(6, 12'h041);	// duplicate of entry 1
		send_access(12'h041, 16'h0036);	// entry 6 wins over entry 1
	endtask

	// back to back accesses over eight blocks
	task automatic run_random();
		logic [BW_REF_ADDR-1:0] r;
		logic [BW_BLOCK-1:0]    b;
		for (int i = 0; i < 200; i++) begin
			r = 12'h040 + 12'(take_bits(4));	// upper half never written
			b = 16'h0020 + 16'(take_bits(3));
			send_access(r, b);
		end
		drive(1'b0, '0, '0, '0);
	endtask

	task automatic wait_reset_release(output logic ok);
		int n;
		n = 0;
		while (resetn !== 1'b1 && n < 20) begin
			@(negedge clock);
			n++;
		end
		ok = (resetn === 1'b1);
		if (!ok) begin
			other_errs++;
			$display("timeout: reset was never released");
		end
	endtask

	task automatic wait_drain(output logic ok);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(negedge clock);
			n++;
		end
		ok = (exp_q.size() == 0);
		if (!ok) begin
			other_errs++;
			$display("timeout: %0d results never came out", exp_q.size());
		end
	endtask

	initial begin
		logic ok;
		cfg_wren   = 1'b0;
		cfg_addr   = '0;
		cfg_data   = '0;
		acc_drv    = '0;
		reset_req  = 1'b0;
		lfsr_q     = 16'd13;
		value_errs = 0;
		other_errs = 0;
		n_checked  = 0;
		model_reset();
		wait_reset_release(ok);
		if (ok) begin
			run_directed();
			run_random();
			wait_drain(ok);
		end
		if (ok) begin
			repeat (2) @(negedge clock);	// stats trail result_o by a cycle
			check_stats(stats, stats_m);
			reset_req = 1'b1;	// second reset
			repeat (2) @(negedge clock);
			reset_req = 1'b0;
			model_reset();
			wait_reset_release(ok);
		end
		if (ok) check_stats(stats, '0);
		$display("checked %0d results: %0d value errors, %0d other errors",
			n_checked, value_errs, other_errs);
		if (ok && value_errs == 0 && other_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/lease_cache_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_cache_props (
	input wire logic                      clock_i,
	input wire logic                      resetn_i,
	input wire logic                      stage_valid_i,	// stage_q.valid of the top
	input wire lease_pkg::access_result_t result_i
);

	// one result per staged access one cycle later
	a_result_follows_stage: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		stage_valid_i |=> result_i.valid
	) else $error("result_o.valid missing one cycle after a staged access");

	a_no_stray_result: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		!stage_valid_i |=> !result_i.valid
	) else $error("result_o.valid high without a staged access");

	// bypassed access gives no lease
	a_bypass_zero_lease: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		(result_i.valid && result_i.bypass) |-> (result_i.lease == '0)
	) else $error("bypass reported with a nonzero lease");

	a_hit_not_bypass: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		result_i.valid |-> !(result_i.cache_hit && result_i.bypass)
	) else $error("cache_hit and bypass both set");

endmodule

bind lease_cache_top lease_cache_props u_props (
	.clock_i       (clock_i),
	.resetn_i      (resetn_i),
	.stage_valid_i (stage_q.valid),
	.result_i      (result_o)
);

`default_nettype wire

// ==== verification/lease_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_clock_gen (
	input  wire logic reset_req_i,	// second reset from the testbench
	output logic      clock_o,
	output logic      resetn_o
);

	logic por_n;	// power on reset

	initial begin
		clock_o = 1'b0;
		forever #4 clock_o = ~clock_o;	// 8 ns period
	end

	// low across two rising edges, released on a falling edge
	initial begin
		por_n = 1'b0;
		repeat (2) @(posedge clock_o);
		@(negedge clock_o);
		por_n = 1'b1;
	end

	assign resetn_o = por_n && !reset_req_i;

endmodule

`default_nettype wire

// ==== logic/lease_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_cache_top (
	input  wire logic                                clock_i,
	input  wire logic                                resetn_i,

	// table config
	input  wire logic                                cfg_wren_i,
	input  wire logic [lease_pkg::BW_ADDR_SPACE-1:0] cfg_addr_i,
	input  wire lease_pkg::cfg_word_u                cfg_data_i,

	// access path
	input  wire lease_pkg::access_req_t              access_i,
	output lease_pkg::access_result_t                result_o,
	output lease_pkg::lease_stats_t                  stats_o
);

	import lease_pkg::*;

	// input registers
	// --------------------
	logic                     cfg_wren_q;
	logic [BW_ADDR_SPACE-1:0] cfg_addr_q;
	cfg_word_u                cfg_data_q;
	access_req_t              stage_q;	// access under lookup
	lookup_t                  lookup;

	// config is staged too, so a same edge write misses the access
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			cfg_wren_q    <= 1'b0;
			stage_q.valid <= 1'b0;
		end else begin
			cfg_wren_q <= cfg_wren_i;
			stage_q    <= access_i;
		end
	end

	always_ff @(posedge clock_i) begin
		cfg_addr_q <= cfg_addr_i;
		cfg_data_q <= cfg_data_i;
	end

	// blocks
	// --------------------
	lease_lookup_table u_table (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.wren_i        (cfg_wren_q),
		.addr_i        (cfg_addr_q),
		.data_i        (cfg_data_q),
		.search_addr_i (stage_q.ref_addr),
		.lookup_o      (lookup)
	);

	lease_line_tracker u_tracker (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.req_i    (stage_q),
		.lookup_i (lookup),
		.result_o (result_o)
	);

	lease_stats u_stats (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.result_i (result_o),	// counts what leaves the top
		.stats_o  (stats_o)
	);

endmodule

`default_nettype wire

// ==== logic/lease_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_stats (
	input  wire logic                     clock_i,
	input  wire logic                     resetn_i,

	input  wire lease_pkg::access_result_t result_i,	// tracker outcome
	output lease_pkg::lease_stats_t       stats_o
);

	import lease_pkg::*;

	// holds at all ones once full
	function automatic logic [BW_STAT-1:0] sat_inc(
		input logic [BW_STAT-1:0] cnt,
		input logic               en
	);
		if (en && cnt != '1) begin
			return cnt + 1'b1;
		end
		return cnt;
	endfunction

	// counters
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			stats_o <= '0;
		end else if (result_i.valid) begin
			stats_o.hits       <= sat_inc(stats_o.hits, result_i.cache_hit);
			stats_o.misses     <= sat_inc(stats_o.misses, !result_i.cache_hit);	// bypass too
			stats_o.bypasses   <= sat_inc(stats_o.bypasses, result_i.bypass);
			stats_o.llt_misses <= sat_inc(stats_o.llt_misses, !result_i.llt_hit);
		end
	end

endmodule

`default_nettype wire

// ==== logic/lease_line_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_line_tracker (
	input  wire logic                     clock_i,
	input  wire logic                     resetn_i,

	input  wire lease_pkg::access_req_t   req_i,	// staged access
	input  wire lease_pkg::lookup_t       lookup_i,	// table answer for req_i
	output lease_pkg::access_result_t     result_o
);

	import lease_pkg::*;

	// line state
	// --------------------
	logic [BW_BLOCK-1:0] tag_q [N_LINES];	// block held by each line
	logic [BW_LEASE-1:0] rem_q [N_LINES];	// remaining lease where 0 means free

	// per line decode
	logic [N_LINES-1:0]  live;			// lease still running
	logic [N_LINES-1:0]  match;			// live and same block
	logic [N_LINES-1:0]  free;			// zero after countdown
	logic [BW_LEASE-1:0] rem_dec [N_LINES];	// lease after countdown

	always_comb begin
		for (int i = 0; i < N_LINES; i++) begin
			live[i]  = (rem_q[i] != '0);
			match[i] = live[i] && (tag_q[i] == req_i.block);

			// every other live line counts down
			if (live[i] && !match[i]) begin
				rem_dec[i] = rem_q[i] - 1'b1;
			end else begin
				rem_dec[i] = rem_q[i];
			end

			free[i] = (rem_dec[i] == '0);
		end
	end

	// index search
	// --------------------
	logic [BW_LINE-1:0] hit_idx;
	logic [BW_LINE-1:0] free_idx;

	// live blocks are never duplicated, so at most one match
	always_comb begin
		hit_idx = '0;
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_idx = BW_LINE'(i);
			end
		end
	end

	// lowest free line
	always_comb begin
		free_idx = '0;
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (free[i]) begin
				free_idx = BW_LINE'(i);
			end
		end
	end

	// decision
	// --------------------
	logic                hit;
	logic                has_free;
	logic                lease_ok;	// table gave a usable lease
	logic                alloc;
	logic [BW_LEASE-1:0] new_lease;

	assign hit      = |match;
	assign has_free = |free;
	assign lease_ok = lookup_i.llt_hit && (lookup_i.lease != '0);
	assign alloc    = !hit && lease_ok && has_free;

	always_comb begin
		if (hit) begin
			// refresh to the table lease or expire on table miss
			new_lease = lookup_i.llt_hit ? lookup_i.lease : '0;
		end else if (alloc) begin
			new_lease = lookup_i.lease;
		end else begin
			new_lease = '0;	// bypass
		end
	end

	access_result_t result_d;

	always_comb begin
		result_d.valid     = req_i.valid;
		result_d.cache_hit = hit;
		result_d.llt_hit   = lookup_i.llt_hit;
		result_d.bypass    = !hit && !alloc;	// no line, zero lease or table miss
		result_d.lease     = new_lease;
		if (hit) begin
			result_d.line = hit_idx;
		end else if (alloc) begin
			result_d.line = free_idx;
		end else begin
			result_d.line = '0;
		end
	end

	// state update
	// --------------------
	// leases only move on a valid access
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < N_LINES; i++) begin
				rem_q[i] <= '0;
			end
		end else if (req_i.valid) begin
			for (int i = 0; i < N_LINES; i++) begin
				rem_q[i] <= rem_dec[i];	// countdown first
			end
			if (hit) begin
				rem_q[hit_idx] <= new_lease;	// refresh overrides
			end else if (alloc) begin
				rem_q[free_idx] <= new_lease;
			end
		end
	end

	// tags only change on allocation
	always_ff @(posedge clock_i) begin
		if (req_i.valid && alloc) begin
			tag_q[free_idx] <= req_i.block;
		end
	end

	// result register one cycle after stage
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			result_o.valid <= 1'b0;
		end else begin
			result_o <= result_d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/lease_lookup_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module lease_lookup_table (
	// system
	input  wire logic                               clock_i,
	input  wire logic                               resetn_i,

	// table writes
	input  wire logic                               wren_i,
	input  wire logic [lease_pkg::BW_ADDR_SPACE-1:0] addr_i,	// select above index
	input  wire lease_pkg::cfg_word_u               data_i,

	// search
	input  wire logic [lease_pkg::BW_REF_ADDR-1:0]  search_addr_i,	// ref word address
	output lease_pkg::lookup_t                      lookup_o
);

	import lease_pkg::*;

	// table storage
	// --------------------
	logic [N_ENTRIES-1:0]   valid_q;			// entry holds a reference
	logic [BW_REF_ADDR-1:0] ref_mem   [N_ENTRIES];
	logic [BW_LEASE-1:0]    lease_mem [N_ENTRIES];

	logic [1:0]            sel;
	logic [BW_ENTRIES-1:0] idx;

	assign sel = addr_i[BW_ADDR_SPACE-1 -: 2];	// table select
	assign idx = addr_i[BW_ENTRIES-1:0];

	// valid bits and leases
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			for (int i = 0; i < N_ENTRIES; i++) begin
				lease_mem[i] <= '0;	// unwritten lease reads as 0
			end
		end else if (wren_i) begin
			case (sel)
				SEL_REF_ADDR: valid_q[idx] <= 1'b1;
				SEL_LEASE0:   lease_mem[idx] <= data_i.lease_view.lease;
				default: ;	// lease1 and probability tables not kept
			endcase
		end
	end

	// reference words
	always_ff @(posedge clock_i) begin
		if (wren_i && sel == SEL_REF_ADDR) begin
			ref_mem[idx] <= data_i.ref_view.word_addr;	// byte to word address
		end
	end

	// search
	// --------------------
	logic [N_ENTRIES-1:0] hit_bits;
	logic [BW_LEASE-1:0]  match_lease;

	// one equality per entry, masked by valid
	always_comb begin
		for (int i = 0; i < N_ENTRIES; i++) begin
			hit_bits[i] = valid_q[i] && (ref_mem[i] == search_addr_i);
		end
	end

	// highest matching index wins
	always_comb begin
		match_lease = '0;
		for (int i = 0; i < N_ENTRIES; i++) begin
			if (hit_bits[i]) begin
				match_lease = lease_mem[i];
			end
		end
	end

	assign lookup_o.llt_hit = |hit_bits;
	assign lookup_o.lease   = match_lease;	// zero when nothing hit

endmodule

`default_nettype wire

// ==== logic/lease_pkg.sv ====
`default_nettype none

package lease_pkg;

	// sizes
	// --------------------
	localparam int N_ENTRIES     = 8;	// lease table entries
	localparam int BW_ENTRIES    = 3;	// table index
	localparam int BW_ADDR_SPACE = 5;	// table select above index
	localparam int BW_REF_ADDR   = 12;	// stored reference word address
	localparam int BW_LEASE      = 8;
	localparam int N_LINES       = 4;	// tracked cache lines
	localparam int BW_LINE       = 2;
	localparam int BW_BLOCK      = 16;	// block address of an access
	localparam int BW_STAT       = 16;	// stats counter width

	// table selects in the top two bits of the config address
	localparam logic [1:0] SEL_REF_ADDR = 2'd0;
	localparam logic [1:0] SEL_LEASE0   = 2'd1;

	// config word
	// --------------------
	// byte address of the reference instruction
	typedef struct packed {
		logic [31-BW_REF_ADDR-2:0] pad;
		logic [BW_REF_ADDR-1:0]    word_addr;	// word address sits above the byte offset
		logic [1:0]                byte_sel;
	} cfg_ref_view_t;

	typedef struct packed {
		logic [31-BW_LEASE:0] pad;
		logic [BW_LEASE-1:0]  lease;	// lease in the low bits
	} cfg_lease_view_t;

	// view picked by the table select of the write
	typedef union packed {
		cfg_ref_view_t   ref_view;
		cfg_lease_view_t lease_view;
	} cfg_word_u;

	// access path
	// --------------------
	typedef struct packed {
		logic                   valid;
		logic [BW_REF_ADDR-1:0] ref_addr;	// word address of the ld/st
		logic [BW_BLOCK-1:0]    block;
	} access_req_t;

	typedef struct packed {
		logic                llt_hit;
		logic [BW_LEASE-1:0] lease;	// zero on table miss
	} lookup_t;

	typedef struct packed {
		logic                valid;
		logic                cache_hit;
		logic                llt_hit;
		logic                bypass;
		logic [BW_LEASE-1:0] lease;	// lease written to the line or 0 on bypass
		logic [BW_LINE-1:0]  line;	// only meaningful without bypass
	} access_result_t;

	typedef struct packed {
		logic [BW_STAT-1:0] hits;
		logic [BW_STAT-1:0] misses;
		logic [BW_STAT-1:0] bypasses;
		logic [BW_STAT-1:0] llt_misses;
	} lease_stats_t;

endpackage

`default_nettype wire
